/* legalizer_pkg.sv */
`default_nettype none

package legalizer_pkg;

    // --------------------
    // bus geometry
    // --------------------
    localparam int unsigned AddrWidth = 32;
    localparam int unsigned DataWidth = 32;
    // bytes per beat and byte-in-beat index bits
    localparam int unsigned StrbWidth = DataWidth / 8;
    localparam int unsigned OffsetWidth = $clog2(StrbWidth);

    // --------------------
    // page limits
    // --------------------
    // AXI4 allows at most 256 beats per incrementing burst
    localparam int unsigned MaxBeatsPerBurst = 256;
    // a page never exceeds the 4 KiB AXI boundary
    localparam int unsigned PageSize = (MaxBeatsPerBurst * StrbWidth > 4096) ?
                                       4096 : MaxBeatsPerBurst * StrbWidth;
    localparam int unsigned PageAddrWidth = $clog2(PageSize);
    // log2 of beats per page when reduce-length is off
    localparam int unsigned LlenDefault = 8;

    // byte address and transfer length
    typedef logic [AddrWidth-1:0] addr_t;
    typedef logic [31:0] len_t;
    // one extra bit so a whole page fits
    typedef logic [PageAddrWidth:0] page_len_t;
    typedef logic [OffsetWidth-1:0] offset_t;
    // reduced log2 beat count
    typedef logic [2:0] llen_t;
    // AXI len field, beats minus one
    typedef logic [$clog2(MaxBeatsPerBurst)-1:0] beats_t;

endpackage

`default_nettype wire

/* legalizer_side_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface legalizer_side_if;
    import legalizer_pkg::*;

    // transfer load pulses on request acceptance
    logic      load;
    addr_t     load_addr;
    len_t      load_length;
    // registered per-side page options
    logic      reduce_len;
    llen_t     max_llen;
    // advance one burst
    logic      step;
    // cut limit chosen by the controller
    page_len_t bytes_possible;
    // side status back to the controller
    page_len_t bytes_to_pb;
    logic      done;
    logic      busy;

    modport ctrl (
        output load, load_addr, load_length, reduce_len, max_llen, step, bytes_possible,
        input  bytes_to_pb, done, busy
    );

    modport side (
        input  load, load_addr, load_length, reduce_len, max_llen, step, bytes_possible,
        output bytes_to_pb, done, busy
    );

endinterface

`default_nettype wire

/* burst_splitter.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_splitter (
    input  wire logic                   clk_i,
    input  wire logic                   reset_i,
    legalizer_side_if.side              ctl,
    output legalizer_pkg::addr_t        burst_addr_o,
    output legalizer_pkg::beats_t       burst_len_o,
    output legalizer_pkg::offset_t      offset_o,
    output legalizer_pkg::offset_t      tailer_o,
    output logic                        last_o
);
    import legalizer_pkg::*;

    // remaining transfer of this side
    addr_t     addr_q;
    len_t      length_q;
    logic      valid_q;

    // page geometry
    logic [3:0]               page_width;
    page_len_t                page_size;
    logic [PageAddrWidth-1:0] page_offset;

    // current burst
    page_len_t num_bytes;
    offset_t   addr_offset;
    page_len_t beat_span;

    // --------------------
    // page boundary
    // --------------------
    // effective page width in address bits
    always_comb begin
        page_width = 4'(OffsetWidth) +
                     (ctl.reduce_len ? 4'(ctl.max_llen) : 4'(LlenDefault));
        // never beyond the AXI page
        if (page_width > 4'(PageAddrWidth)) begin
            page_width = 4'(PageAddrWidth);
        end
    end

    assign page_size = page_len_t'(1) << page_width;

    // low address bits below the variable page width
    always_comb begin
        page_offset = '0;
        for (int i = 0; i < PageAddrWidth; i++) begin
            page_offset[i] = (page_width > 4'(i)) ? addr_q[i] : 1'b0;
        end
    end

    assign ctl.bytes_to_pb = page_size - page_len_t'(page_offset);

    // --------------------
    // burst cut
    // --------------------
    assign ctl.done = !valid_q || (length_q <= len_t'(ctl.bytes_possible));

    // whole remainder when it fits, otherwise up to the limit
    assign num_bytes = (length_q > len_t'(ctl.bytes_possible)) ?
                       ctl.bytes_possible : length_q[PageAddrWidth:0];

    assign addr_offset = addr_q[OffsetWidth-1:0];

    // bytes touched from the aligned start, minus one
    assign beat_span = num_bytes + page_len_t'(addr_offset) - page_len_t'(1);

    assign burst_addr_o = {addr_q[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};
    assign burst_len_o  = beats_t'(beat_span >> OffsetWidth);
    assign offset_o     = addr_offset;
    assign tailer_o     = offset_t'(num_bytes + page_len_t'(addr_offset));
    // only a burst in flight can be the last one
    assign last_o       = valid_q & ctl.done;
    assign ctl.busy     = valid_q;

    // --------------------
    // state
    // --------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (ctl.load) begin
            // zero-length transfers emit nothing
            valid_q <= |ctl.load_length;
        end else if (ctl.step && valid_q && ctl.done) begin
            valid_q <= 1'b0;
        end
    end

    // address and remainder of the transfer
    always_ff @(posedge clk_i) begin
        if (ctl.load) begin
            addr_q   <= ctl.load_addr;
            length_q <= ctl.load_length;
        end else if (ctl.step && valid_q && !ctl.done) begin
            // move past the emitted burst
            addr_q   <= addr_q + addr_t'(ctl.bytes_possible);
            length_q <= length_q - len_t'(ctl.bytes_possible);
        end
    end

endmodule

`default_nettype wire

/* legalizer_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module legalizer_ctrl (
    input  wire logic                 clk_i,
    input  wire logic                 reset_i,
    // request
    input  legalizer_pkg::addr_t      req_src_addr_i,
    input  legalizer_pkg::addr_t      req_dst_addr_i,
    input  legalizer_pkg::len_t       req_length_i,
    input  wire logic                 req_decouple_rw_i,
    input  wire logic                 req_src_reduce_len_i,
    input  legalizer_pkg::llen_t      req_src_max_llen_i,
    input  wire logic                 req_dst_reduce_len_i,
    input  legalizer_pkg::llen_t      req_dst_max_llen_i,
    input  wire logic                 req_valid_i,
    output logic                      req_ready_o,
    // burst flow control
    input  wire logic                 r_ready_i,
    input  wire logic                 w_ready_i,
    input  wire logic                 flush_i,
    output logic                      r_valid_o,
    output logic                      w_valid_o,
    // splitter sides
    legalizer_side_if.ctrl            rd_side,
    legalizer_side_if.ctrl            wr_side
);
    import legalizer_pkg::*;

    // options of the running transfer
    logic  decouple_q;
    logic  src_reduce_q;
    llen_t src_max_llen_q;
    logic  dst_reduce_q;
    llen_t dst_max_llen_q;

    logic      accept;
    logic      coupled_step;
    page_len_t c_bytes_to_pb;

    // --------------------
    // request intake
    // --------------------
    // both sides finished and both channels able to take a burst
    assign req_ready_o = rd_side.done & wr_side.done & r_ready_i & w_ready_i & !flush_i;
    assign accept      = req_valid_i & req_ready_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            decouple_q     <= 1'b0;
            src_reduce_q   <= 1'b0;
            src_max_llen_q <= '0;
            dst_reduce_q   <= 1'b0;
            dst_max_llen_q <= '0;
        end else if (accept) begin
            decouple_q     <= req_decouple_rw_i;
            src_reduce_q   <= req_src_reduce_len_i;
            src_max_llen_q <= req_src_max_llen_i;
            dst_reduce_q   <= req_dst_reduce_len_i;
            dst_max_llen_q <= req_dst_max_llen_i;
        end
    end

    // source feeds the read side, destination the write side
    assign rd_side.load        = accept;
    assign rd_side.load_addr   = req_src_addr_i;
    assign rd_side.load_length = req_length_i;
    assign rd_side.reduce_len  = src_reduce_q;
    assign rd_side.max_llen    = src_max_llen_q;

    assign wr_side.load        = accept;
    assign wr_side.load_addr   = req_dst_addr_i;
    assign wr_side.load_length = req_length_i;
    assign wr_side.reduce_len  = dst_reduce_q;
    assign wr_side.max_llen    = dst_max_llen_q;

    // --------------------
    // cut limits
    // --------------------
    // nearer boundary of the two sides
    assign c_bytes_to_pb = (rd_side.bytes_to_pb > wr_side.bytes_to_pb) ?
                           wr_side.bytes_to_pb : rd_side.bytes_to_pb;

    assign rd_side.bytes_possible = decouple_q ? rd_side.bytes_to_pb : c_bytes_to_pb;
    assign wr_side.bytes_possible = decouple_q ? wr_side.bytes_to_pb : c_bytes_to_pb;

    // --------------------
    // flow control
    // --------------------
    // coupled sides only move when both channels accept
    assign coupled_step = r_ready_i & w_ready_i & !flush_i;

    assign rd_side.step = decouple_q ? (r_ready_i & !flush_i) : coupled_step;
    assign wr_side.step = decouple_q ? (w_ready_i & !flush_i) : coupled_step;

    // valid only ever rises with its ready, so each valid cycle is a burst
    assign r_valid_o = rd_side.busy & rd_side.step;
    assign w_valid_o = wr_side.busy & wr_side.step;

endmodule

`default_nettype wire

/* burst_legalizer.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_legalizer (
    input  wire logic                 clk_i,
    input  wire logic                 reset_i,
    // request
    input  legalizer_pkg::addr_t      req_src_addr_i,
    input  legalizer_pkg::addr_t      req_dst_addr_i,
    input  legalizer_pkg::len_t       req_length_i,
    input  wire logic                 req_decouple_rw_i,
    input  wire logic                 req_src_reduce_len_i,
    input  legalizer_pkg::llen_t      req_src_max_llen_i,
    input  wire logic                 req_dst_reduce_len_i,
    input  legalizer_pkg::llen_t      req_dst_max_llen_i,
    input  wire logic                 req_valid_i,
    output logic                      req_ready_o,
    // read bursts
    output legalizer_pkg::addr_t      ar_addr_o,
    output legalizer_pkg::beats_t     ar_len_o,
    output legalizer_pkg::offset_t    r_offset_o,
    output legalizer_pkg::offset_t    r_tailer_o,
    output logic                      r_valid_o,
    input  wire logic                 r_ready_i,
    // write bursts
    output legalizer_pkg::addr_t      aw_addr_o,
    output legalizer_pkg::beats_t     aw_len_o,
    output legalizer_pkg::offset_t    w_offset_o,
    output legalizer_pkg::offset_t    w_tailer_o,
    output logic                      w_last_o,
    output logic                      w_valid_o,
    input  wire logic                 w_ready_i,
    // control and status
    input  wire logic                 flush_i,
    output logic                      r_busy_o,
    output logic                      w_busy_o
);

    legalizer_side_if rd_if ();
    legalizer_side_if wr_if ();

    // --------------------
    // controller
    // --------------------
    legalizer_ctrl u_ctrl (
        .clk_i                (clk_i),
        .reset_i              (reset_i),
        .req_src_addr_i       (req_src_addr_i),
        .req_dst_addr_i       (req_dst_addr_i),
        .req_length_i         (req_length_i),
        .req_decouple_rw_i    (req_decouple_rw_i),
        .req_src_reduce_len_i (req_src_reduce_len_i),
        .req_src_max_llen_i   (req_src_max_llen_i),
        .req_dst_reduce_len_i (req_dst_reduce_len_i),
        .req_dst_max_llen_i   (req_dst_max_llen_i),
        .req_valid_i          (req_valid_i),
        .req_ready_o          (req_ready_o),
        .r_ready_i            (r_ready_i),
        .w_ready_i            (w_ready_i),
        .flush_i              (flush_i),
        .r_valid_o            (r_valid_o),
        .w_valid_o            (w_valid_o),
        .rd_side              (rd_if.ctrl),
        .wr_side              (wr_if.ctrl)
    );

    // --------------------
    // splitters
    // --------------------
    // the write side alone marks the last burst
    burst_splitter u_rd (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .ctl          (rd_if.side),
        .burst_addr_o (ar_addr_o),
        .burst_len_o  (ar_len_o),
        .offset_o     (r_offset_o),
        .tailer_o     (r_tailer_o),
        .last_o       ()
    );

    burst_splitter u_wr (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .ctl          (wr_if.side),
        .burst_addr_o (aw_addr_o),
        .burst_len_o  (aw_len_o),
        .offset_o     (w_offset_o),
        .tailer_o     (w_tailer_o),
        .last_o       (w_last_o)
    );

    // a side is busy while it holds an unfinished transfer
    assign r_busy_o = rd_if.busy;
    assign w_busy_o = wr_if.busy;

endmodule

`default_nettype wire

/* tb_burst_legalizer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_burst_legalizer;
    import legalizer_pkg::*;

    // one expected burst
    // last only matters on the write side
    typedef struct packed {
        addr_t   addr;
        beats_t  len;
        offset_t off;
        offset_t tail;
        logic    last;
    } burst_t;

    logic    clk_i;
    logic    reset_i;
    addr_t   req_src_addr_i;
    addr_t   req_dst_addr_i;
    len_t    req_length_i;
    logic    req_decouple_rw_i;
    logic    req_src_reduce_len_i;
    llen_t   req_src_max_llen_i;
    logic    req_dst_reduce_len_i;
    llen_t   req_dst_max_llen_i;
    logic    req_valid_i;
    logic    req_ready_o;
    addr_t   ar_addr_o;
    beats_t  ar_len_o;
    offset_t r_offset_o;
    offset_t r_tailer_o;
    logic    r_valid_o;
    logic    r_ready_i;
    addr_t   aw_addr_o;
    beats_t  aw_len_o;
    offset_t w_offset_o;
    offset_t w_tailer_o;
    logic    w_last_o;
    logic    w_valid_o;
    logic    w_ready_i;
    logic    flush_i;
    logic    r_busy_o;
    logic    w_busy_o;

    // expected bursts per channel, oldest first
    burst_t      exp_rd[$];
    burst_t      exp_wr[$];
    int          main_errors = 0;
    int          mon_errors = 0;
    int          r_flow_errors = 0;
    int          w_flow_errors = 0;
    int          lockstep_errors = 0;
    int          burst_budget = 0;
    int          cycle_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_base = 0;
    logic        jitter_on = 1'b0;
    logic [31:0] lfsr_q = 32'hf0f1ccfc;
    // decouple option of the transfer in flight
    logic        cur_decouple;

    burst_legalizer UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // --------------------
    // helpers
    // --------------------
    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    function automatic int check_value(input string name, input logic [31:0] got,
                                       input logic [31:0] exp);
        assert (got == exp) else $display("Fail %s got %h exp %h", name, got, exp);
        return (got == exp) ? 0 : 1;
    endfunction

    function automatic int total_errors();
        return main_errors + mon_errors + r_flow_errors + w_flow_errors + lockstep_errors;
    endfunction

    // page bits are beat offset plus log2 beats, capped at the 1 KiB page
    function automatic int page_width(input logic reduce, input llen_t llen);
        int w;
        w = int'(OffsetWidth) + (reduce ? int'(llen) : int'(LlenDefault));
        return (w > int'(PageAddrWidth)) ? int'(PageAddrWidth) : w;
    endfunction

    function automatic logic [31:0] page_room(input addr_t a, input int w);
        logic [31:0] size;
        size = 32'd1 << w;
        return size - (a & (size - 32'd1));
    endfunction

    function automatic burst_t make_burst(input addr_t a, input logic [31:0] cut,
                                          input logic last);
        burst_t      b;
        logic [31:0] end_byte;
        // bytes from the aligned beat start to the end of the burst
        end_byte = cut + 32'(a[OffsetWidth-1:0]);
        b.addr = a & ~addr_t'(StrbWidth - 1);
        b.len  = beats_t'((end_byte - 32'd1) >> OffsetWidth);
        b.off  = offset_t'(a);
        b.tail = offset_t'(end_byte);
        b.last = last;
        return b;
    endfunction

    // aligned beats of a burst stay inside one 1 KiB page
    function automatic logic fits_page(input addr_t a, input beats_t len);
        logic [31:0] span;
        span = 32'(a[PageAddrWidth-1:0]) + (32'(len) + 32'd1) * StrbWidth;
        return span <= PageSize;
    endfunction

    // --------------------
    // reference splitting
    // --------------------
    task automatic build_model(input addr_t src, input addr_t dst, input len_t length,
                               input logic decouple, input int rw, input int ww);
        addr_t       ra;
        addr_t       wa;
        len_t        rl;
        len_t        wl;
        logic [31:0] rlim;
        logic [31:0] wlim;
        logic [31:0] cut;
        int          nr;
        int          nw;
        ra = src;
        wa = dst;
        rl = length;
        wl = length;
        nr = 0;
        nw = 0;
        while (rl != 0 || wl != 0) begin
            rlim = page_room(ra, rw);
            wlim = page_room(wa, ww);
            // coupled sides share the nearer boundary
            if (!decouple) begin
                rlim = (rlim < wlim) ? rlim : wlim;
                wlim = rlim;
            end
            if (rl != 0) begin
                cut = (rl < rlim) ? rl : rlim;
                exp_rd.push_back(make_burst(ra, cut, rl <= rlim));
                ra = ra + cut;
                rl = rl - cut;
                nr = nr + 1;
            end
            if (wl != 0) begin
                cut = (wl < wlim) ? wl : wlim;
                exp_wr.push_back(make_burst(wa, cut, wl <= wlim));
                wa = wa + cut;
                wl = wl - cut;
                nw = nw + 1;
            end
        end
        burst_budget = burst_budget + ((nr > nw) ? nr : nw) + 1;
    endtask

    // --------------------
    // stimulus
    // --------------------
    task automatic run_transfer(input addr_t src, input addr_t dst, input len_t length,
                                input logic decouple, input logic s_red, input llen_t s_llen,
                                input logic d_red, input llen_t d_llen);
        logic taken;
        build_model(src, dst, length, decouple, page_width(s_red, s_llen),
                    page_width(d_red, d_llen));
        @(negedge clk_i);
        req_src_addr_i       = src;
        req_dst_addr_i       = dst;
        req_length_i         = length;
        req_decouple_rw_i    = decouple;
        req_src_reduce_len_i = s_red;
        req_src_max_llen_i   = s_llen;
        req_dst_reduce_len_i = d_red;
        req_dst_max_llen_i   = d_llen;
        req_valid_i          = 1'b1;
        // hold the request until an edge sees ready
        do begin
            @(posedge clk_i);
            taken = req_ready_o;
            @(negedge clk_i);
        end while (!taken);
        req_valid_i = 1'b0;
    endtask

    task automatic wait_idle();
        do begin
            @(negedge clk_i);
        end while (r_busy_o || w_busy_o);
        assert (exp_rd.size() == 0 && exp_wr.size() == 0) else begin
            main_errors = main_errors + 1;
            $display("sides went idle with %0d read and %0d write bursts never seen",
                     exp_rd.size(), exp_wr.size());
        end
    endtask

    task automatic finish_test(input int num, input string name);
        tests_run = tests_run + 1;
        if (total_errors() != test_base) begin
            tests_failed = tests_failed + 1;
            $display("check %0d %s: %0d errors", num, name, total_errors() - test_base);
        end else begin
            $display("check %0d %s: ok", num, name);
        end
        test_base = total_errors();
    endtask

    // readies and flush stay random only while jitter is on
    initial begin : ready_stream
        logic [31:0] bits;
        r_ready_i = 1'b1;
        w_ready_i = 1'b1;
        flush_i   = 1'b0;
        forever begin
            @(negedge clk_i);
            if (jitter_on) begin
                take_bits(2, bits);
                r_ready_i = |bits[1:0];
                take_bits(2, bits);
                w_ready_i = |bits[1:0];
                // short flush pulses about one cycle in eight
                take_bits(3, bits);
                flush_i = &bits[2:0];
            end else begin
                r_ready_i = 1'b1;
                w_ready_i = 1'b1;
                flush_i   = 1'b0;
            end
        end
    end

    // --------------------
    // checking
    // --------------------
    task automatic check_burst(input string bus, input string ch, input burst_t exp_b,
                               input burst_t got, input logic with_last);
        int n;
        n = check_value($sformatf("%s_addr_o", bus), got.addr, exp_b.addr);
        n = n + check_value($sformatf("%s_len_o", bus), 32'(got.len), 32'(exp_b.len));
        n = n + check_value($sformatf("%s_offset_o", ch), 32'(got.off), 32'(exp_b.off));
        n = n + check_value($sformatf("%s_tailer_o", ch), 32'(got.tail), 32'(exp_b.tail));
        if (with_last) begin
            n = n + check_value("w_last_o", 32'(got.last), 32'(exp_b.last));
        end
        assert (fits_page(got.addr, got.len)) else begin
            n = n + 1;
            $display("%s_addr_o %h with len %h crosses a 1 KiB page", bus, got.addr, got.len);
        end
        mon_errors = mon_errors + n;
    endtask

    // every valid cycle is one burst taken by the channel
    always @(posedge clk_i) begin
        if (!reset_i && r_valid_o) begin
            if (exp_rd.size() == 0) begin
                mon_errors = mon_errors + 1;
                $display("read burst at %h arrived with none expected", ar_addr_o);
            end else begin
                check_burst("ar", "r", exp_rd.pop_front(),
                            {ar_addr_o, ar_len_o, r_offset_o, r_tailer_o, 1'b0}, 1'b0);
            end
        end
        if (!reset_i && w_valid_o) begin
            if (exp_wr.size() == 0) begin
                mon_errors = mon_errors + 1;
                $display("write burst at %h arrived with none expected", aw_addr_o);
            end else begin
                check_burst("aw", "w", exp_wr.pop_front(),
                            {aw_addr_o, aw_len_o, w_offset_o, w_tailer_o, w_last_o}, 1'b1);
            end
        end
    end

    // mode follows the request handshake
    always @(posedge clk_i) begin
        if (reset_i) begin
            cur_decouple <= 1'b0;
        end else if (req_valid_i && req_ready_o) begin
            cur_decouple <= req_decouple_rw_i;
        end
    end

    assert property (@(posedge clk_i) disable iff (reset_i) r_valid_o |-> (r_ready_i && !flush_i))
        else begin
            r_flow_errors = r_flow_errors + 1;
            $display("read valid high while r_ready_i low or flush_i high");
        end

    assert property (@(posedge clk_i) disable iff (reset_i) w_valid_o |-> (w_ready_i && !flush_i))
        else begin
            w_flow_errors = w_flow_errors + 1;
            $display("write valid high while w_ready_i low or flush_i high");
        end

    // coupled sides hand out their bursts in the same cycles
    assert property (@(posedge clk_i) disable iff (reset_i)
                     !cur_decouple |-> (r_valid_o == w_valid_o))
        else begin
            lockstep_errors = lockstep_errors + 1;
            $display("coupled transfer with read and write valids out of step");
        end

    // limit grows with the bursts queued so far
    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > 200 + 40 * burst_budget) begin
            $display("run stopped after %0d cycles with bursts still outstanding", cycle_count);
            $display("test failed");
            $finish;
        end
    end

    // --------------------
    // test sequence
    // --------------------
    initial begin
        reset_i              = 1'b1;
        req_src_addr_i       = '0;
        req_dst_addr_i       = '0;
        req_length_i         = '0;
        req_decouple_rw_i    = 1'b0;
        req_src_reduce_len_i = 1'b0;
        req_src_max_llen_i   = '0;
        req_dst_reduce_len_i = 1'b0;
        req_dst_max_llen_i   = '0;
        req_valid_i          = 1'b0;
        repeat (2) @(negedge clk_i);
        reset_i = 1'b0;

        // idle outputs right after reset
        @(posedge clk_i);
        main_errors = main_errors + check_value("r_busy_o", 32'(r_busy_o), 32'd0);
        main_errors = main_errors + check_value("w_busy_o", 32'(w_busy_o), 32'd0);
        main_errors = main_errors + check_value("r_valid_o", 32'(r_valid_o), 32'd0);
        main_errors = main_errors + check_value("w_valid_o", 32'(w_valid_o), 32'd0);
        main_errors = main_errors + check_value("w_last_o", 32'(w_last_o), 32'd0);
        main_errors = main_errors + check_value("req_ready_o", 32'(req_ready_o), 32'd1);
        @(negedge clk_i);
        finish_test(1, "reset state");

        run_transfer(32'h0000_1000, 32'h0000_2040, 256, 1'b0, 1'b0, 3'd0, 1'b0, 3'd0);
        wait_idle();
        finish_test(2, "aligned single page");

        // same page phase coupled, then different phases decoupled
        run_transfer(32'h0000_03f0, 32'h0000_83f0, 2100, 1'b0, 1'b0, 3'd0, 1'b0, 3'd0);
        run_transfer(32'h0001_03fa, 32'h0002_0200, 1500, 1'b1, 1'b0, 3'd0, 1'b0, 3'd0);
        wait_idle();
        finish_test(3, "page crossing");

        run_transfer(32'h0000_0105, 32'h0000_0203, 50, 1'b1, 1'b1, 3'd2, 1'b1, 3'd2);
        wait_idle();
        finish_test(4, "reduced length");

        run_transfer(32'h0000_1236, 32'h0000_57f9, 3000, 1'b0, 1'b0, 3'd0, 1'b0, 3'd0);
        wait_idle();
        run_transfer(32'h0000_1236, 32'h0000_57f9, 3000, 1'b1, 1'b0, 3'd0, 1'b0, 3'd0);
        wait_idle();
        finish_test(5, "coupled and decoupled");

        // back to back requests under random readies and flush
        @(posedge clk_i);
        jitter_on = 1'b1;
        @(negedge clk_i);
        run_transfer(32'h0004_0ffd, 32'h0006_1002, 700, 1'b1, 1'b1, 3'd3, 1'b0, 3'd0);
        run_transfer(32'h0004_2222, 32'h0006_3ffe, 1300, 1'b0, 1'b0, 3'd0, 1'b1, 3'd5);
        run_transfer(32'h0004_5001, 32'h0006_5001, 9, 1'b1, 1'b0, 3'd0, 1'b0, 3'd0);
        run_transfer(32'h0004_77f3, 32'h0006_7a01, 2500, 1'b0, 1'b1, 3'd0, 1'b1, 3'd7);
        wait_idle();
        @(posedge clk_i);
        jitter_on = 1'b0;
        @(negedge clk_i);
        finish_test(6, "back-pressure and flush");

        $display("%0d checks run, %0d with errors, %0d errors in total",
                 tests_run, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* burst_legalizer.f */
legalizer_pkg.sv
legalizer_side_if.sv
burst_splitter.sv
legalizer_ctrl.sv
burst_legalizer.sv
tb_burst_legalizer.sv

/* Makefile */
TOP = tb_burst_legalizer

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f burst_legalizer.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "test passed"

clean:
	rm -rf obj_dir
